// File: include/quarkCore_config.svh
/* Core build constants for the quark RV32I core.
   The address width bounds the program counter and all address adders. */
`ifndef QUARK_CORE_CONFIG_SVH
`define QUARK_CORE_CONFIG_SVH

// First fetch address after reset
`define QUARK_RESET_ADDR 32'h00000000
// Width of PC and internal address logic
`define QUARK_ADDR_WIDTH 24
// Data word width
`define QUARK_XLEN 32
// Number of integer registers, x0 included
`define QUARK_NUM_REGS 32

`endif

// File: hw/isaPkg.sv
/* RV32I instruction-set types.
   Opcodes come from instruction bits 6 to 2; unknown codes map to opIllegal. */
package isaPkg;

   // Base opcode field, instr[6:2]
   typedef enum logic [4:0] {
      opLoad    = 5'b00000,
      opAluImm  = 5'b00100,
      opAuipc   = 5'b00101,
      opStore   = 5'b01000,
      opAluReg  = 5'b01100,
      opLui     = 5'b01101,
      opBranch  = 5'b11000,
      opJalr    = 5'b11001,
      opJal     = 5'b11011,
      opSystem  = 5'b11100,
      // Reserved code, used for anything not listed above
      opIllegal = 5'b11111
   } opcodeE;

   // funct3 meaning for ALU instructions
   typedef enum logic [2:0] {
      aluAddSub = 3'd0,
      aluSll    = 3'd1,
      aluSlt    = 3'd2,
      aluSltu   = 3'd3,
      aluXor    = 3'd4,
      aluSrl    = 3'd5,
      aluOr     = 3'd6,
      aluAnd    = 3'd7
   } aluFunctE;

   // funct3 meaning for conditional branches
   typedef enum logic [2:0] {
      brEq  = 3'd0,
      brNe  = 3'd1,
      brLt  = 3'd4,
      brGe  = 3'd5,
      brLtu = 3'd6,
      brGeu = 3'd7
   } branchFunctE;

   // Raw 32-bit instruction word
   typedef logic [31:0] instrWordT;

endpackage

// File: hw/corePkg.sv
/* Micro-architecture types of the quark core.
   Sequencer state is one-hot. */
`include "quarkCore_config.svh"

package corePkg;

   // One bit per sequencer state
   typedef enum logic [3:0] {
      fetchInstr = 4'b0001,
      waitInstr  = 4'b0010,
      execute    = 4'b0100,
      waitMem    = 4'b1000
   } seqStateE;

   // Internal address, narrower than the bus
   typedef logic [`QUARK_ADDR_WIDTH-1:0] coreAddrT;

endpackage

// File: hw/decodeIf.sv
/* Decoded fields of the instruction currently held by the decoder.
   Fields are stable from the cycle after capture until the next capture. */
`timescale 1ns/100ps

interface decodeIf;
   import isaPkg::*;

   // Major opcode, illegal for unknown codes
   opcodeE      opcode;
   logic [2:0]  funct3;
   // Destination register index
   logic [4:0]  rdId;
   // Immediate already chosen by format
   logic [31:0] imm;
   // instr[30], SUB and SRA select
   logic        altBit;
   // instr[5], register form of ALU ops
   logic        regForm;

   modport producer (output opcode, funct3, rdId, imm, altBit, regForm);
   modport consumer (input opcode, funct3, rdId, imm, altBit, regForm);

endinterface

// File: hw/instrDecoder.sv
/* Instruction register and field decode.
   Bits 1:0 of the fetched word are not kept, as RV32I has no compressed forms. */
`timescale 1ns/100ps

module instrDecoder (
   input  logic              clk,
   input  logic              capture,
   input  isaPkg::instrWordT memRdata,
   decodeIf.producer         dec
);
   import isaPkg::*;

   logic [31:2] instr;
   opcodeE      opcode;
   logic [31:0] iImm;
   logic [31:0] sImm;
   logic [31:0] bImm;
   logic [31:0] uImm;
   logic [31:0] jImm;

   // Load on the fetch handshake only
   always_ff @(posedge clk) begin
      if (capture) begin
         instr <= memRdata[31:2];
      end
   end

   // Five immediate formats, all sign extended from bit 31
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign uImm = {instr[31:12], 12'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      case (instr[6:2])
         opLoad, opAluImm, opAuipc, opStore, opAluReg,
         opLui, opBranch, opJalr, opJal, opSystem:
            opcode = opcodeE'(instr[6:2]);
         default: opcode = opIllegal;
      endcase
   end

   // One immediate per opcode so consumers never pick a format
   always_comb begin
      case (opcode)
         opStore:       dec.imm = sImm;
         opBranch:      dec.imm = bImm;
         opLui, opAuipc: dec.imm = uImm;
         opJal:         dec.imm = jImm;
         // Loads, ALU immediate and JALR
         default:       dec.imm = iImm;
      endcase
   end

   assign dec.opcode  = opcode;
   assign dec.funct3  = instr[14:12];
   assign dec.rdId    = instr[11:7];
   assign dec.altBit  = instr[30];
   assign dec.regForm = instr[5];

endmodule

// File: hw/registerFile.sv
/* Integer register file with registered two-port read.
   Read indices come straight from the fetched word; x0 always reads zero. */
`timescale 1ns/100ps
`include "quarkCore_config.svh"

module registerFile (
   input  logic                   clk,
   input  logic                   capture,
   input  isaPkg::instrWordT      memRdata,
   input  logic                   wbEnable,
   input  logic [4:0]             rdId,
   input  logic [`QUARK_XLEN-1:0] wbData,
   output logic [`QUARK_XLEN-1:0] rs1,
   output logic [`QUARK_XLEN-1:0] rs2
);

   logic [`QUARK_XLEN-1:0] regs [`QUARK_NUM_REGS];
   logic [4:0]             rs1Id;
   logic [4:0]             rs2Id;

   // Source fields of the word on the bus
   assign rs1Id = memRdata[19:15];
   assign rs2Id = memRdata[24:20];

   // Operands sampled together with the instruction
   always_ff @(posedge clk) begin
      if (capture) begin
         rs1 <= (rs1Id == 5'd0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == 5'd0) ? '0 : regs[rs2Id];
      end
   end

   // Writes to x0 dropped
   always_ff @(posedge clk) begin
      if (wbEnable && rdId != 5'd0) begin
         regs[rdId] <= wbData;
      end
   end

endmodule

// File: hw/aluUnit.sv
/* Combinational ALU and branch compare.
   Left shifts run through the right shifter with bit reversal.
   takeBranch is the raw predicate and is meaningful for branches only. */
`timescale 1ns/100ps

module aluUnit (
   decodeIf.consumer   dec,
   input  logic [31:0] rs1,
   input  logic [31:0] rs2,
   output logic [31:0] aluResult,
   output logic [31:0] aluSum,
   output logic        takeBranch
);
   import isaPkg::*;

   logic [31:0] aluIn2;
   logic [32:0] aluMinus;
   logic        lt;
   logic        ltu;
   logic        eq;
   logic [31:0] shiftIn;
   logic [32:0] shiftWide;
   logic [31:0] shiftRight;
   aluFunctE    aluOp;
   branchFunctE brOp;

   function automatic logic [31:0] reverseBits(input logic [31:0] value);
      logic [31:0] result;
      for (int i = 0; i < 32; i++) begin
         result[i] = value[31-i];
      end
      return result;
   endfunction

   assign aluOp = aluFunctE'(dec.funct3);
   assign brOp  = branchFunctE'(dec.funct3);

   // Register operand for ALU register form and branches
   assign aluIn2 = (dec.opcode == opAluReg || dec.opcode == opBranch) ? rs2 : dec.imm;

   // Plain sum, also the JALR target
   assign aluSum = rs1 + aluIn2;

   // One 33-bit subtract for SUB and all compares
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign lt       = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32];
   assign ltu      = aluMinus[32];
   assign eq       = (aluMinus[31:0] == 32'd0);

   // Extra top bit carries the sign for SRA
   assign shiftIn    = (aluOp == aluSll) ? reverseBits(rs1) : rs1;
   assign shiftWide  = $signed({dec.altBit & rs1[31], shiftIn}) >>> aluIn2[4:0];
   assign shiftRight = shiftWide[31:0];

   always_comb begin
      case (aluOp)
         // SUB only in register form, ADDI reuses bit 30 as immediate
         aluAddSub: aluResult = (dec.altBit & dec.regForm) ? aluMinus[31:0] : aluSum;
         aluSll:    aluResult = reverseBits(shiftRight);
         aluSlt:    aluResult = {31'b0, lt};
         aluSltu:   aluResult = {31'b0, ltu};
         aluXor:    aluResult = rs1 ^ aluIn2;
         aluSrl:    aluResult = shiftRight;
         aluOr:     aluResult = rs1 | aluIn2;
         default:   aluResult = rs1 & aluIn2;
      endcase
   end

   always_comb begin
      case (brOp)
         brEq:    takeBranch = eq;
         brNe:    takeBranch = !eq;
         brLt:    takeBranch = lt;
         brGe:    takeBranch = !lt;
         brLtu:   takeBranch = ltu;
         brGeu:   takeBranch = !ltu;
         // funct3 2 and 3 are not branches
         default: takeBranch = 1'b0;
      endcase
   end

endmodule

// File: hw/execSequencer.sv
/* Multi-cycle sequencer, program counter and bus control.
   Word accesses only: store mask is always 1111 and address bits 1:0 are cleared.
   The PC holds QUARK_ADDR_WIDTH bits; higher address bits read back as zero. */
`timescale 1ns/100ps
`include "quarkCore_config.svh"

module execSequencer (
   input  logic                   clk,
   input  logic                   reset,
   decodeIf.consumer              dec,
   input  logic [`QUARK_XLEN-1:0] rs1,
   input  logic [`QUARK_XLEN-1:0] rs2,
   input  logic [`QUARK_XLEN-1:0] aluResult,
   input  logic [`QUARK_XLEN-1:0] aluSum,
   input  logic                   takeBranch,
   input  logic [`QUARK_XLEN-1:0] memRdata,
   input  logic                   memRbusy,
   input  logic                   memWbusy,
   output logic                   capture,
   output logic                   wbEnable,
   output logic [`QUARK_XLEN-1:0] wbData,
   output logic [`QUARK_XLEN-1:0] memAddr,
   output logic [`QUARK_XLEN-1:0] memWdata,
   output logic [3:0]             memWmask,
   output logic                   memRstrb
);
   import isaPkg::*;
   import corePkg::*;

   localparam int padBits = `QUARK_XLEN - `QUARK_ADDR_WIDTH;

   seqStateE               state;
   coreAddrT               pc;
   coreAddrT               pcPlus4;
   logic [`QUARK_XLEN-1:0] pcPlusImm;
   coreAddrT               lsAddr;
   coreAddrT               pcNext;
   coreAddrT               busAddr;
   logic                   isLoad;
   logic                   isStore;
   logic                   jumpToImm;
   logic                   writesReg;

   assign isLoad    = (dec.opcode == opLoad);
   assign isStore   = (dec.opcode == opStore);
   assign jumpToImm = (dec.opcode == opJal) | (dec.opcode == opBranch & takeBranch);

   assign pcPlus4 = pc + coreAddrT'(4);
   // Full width so AUIPC keeps the upper immediate bits
   assign pcPlusImm = {{padBits{1'b0}}, pc} + dec.imm;
   // Load/store address, word aligned
   assign lsAddr = (rs1[`QUARK_ADDR_WIDTH-1:0] + dec.imm[`QUARK_ADDR_WIDTH-1:0]) &
                   ~coreAddrT'(3);

   // JALR clears bit 0 of the target
   assign pcNext = (dec.opcode == opJalr) ? {aluSum[`QUARK_ADDR_WIDTH-1:1], 1'b0} :
                   jumpToImm ? pcPlusImm[`QUARK_ADDR_WIDTH-1:0] : pcPlus4;

   // Bus owner follows state; execute prefetches the next instruction
   assign busAddr = (state == fetchInstr || state == waitInstr) ? pc :
                    (state == execute && !isLoad && !isStore) ? pcNext : lsAddr;
   assign memAddr = {{padBits{1'b0}}, busAddr};

   assign memRstrb = (state == fetchInstr) | (state == execute & !isStore);
   assign memWmask = {4{state == execute & isStore}};
   assign memWdata = rs2;
   assign capture  = (state == waitInstr) & !memRbusy;

   // Writeback source by opcode
   always_comb begin
      wbData    = '0;
      writesReg = 1'b1;
      case (dec.opcode)
         opLui:              wbData = dec.imm;
         opAluImm, opAluReg: wbData = aluResult;
         opAuipc:            wbData = pcPlusImm;
         opJal, opJalr:      wbData = {{padBits{1'b0}}, pcPlus4};
         opLoad:             wbData = memRdata;
         // Branch, store, system, illegal
         default:            writesReg = 1'b0;
      endcase
   end

   // Loads write while waiting; final write lands when busy drops
   assign wbEnable = writesReg & ((state == execute & !isLoad) | (state == waitMem & isLoad));

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Wait for the memory to go idle before the first fetch
         state <= waitMem;
         pc    <= coreAddrT'(`QUARK_RESET_ADDR);
      end else begin
         case (state)
            waitInstr: begin
               if (!memRbusy) begin
                  state <= execute;
               end
            end
            execute: begin
               pc    <= pcNext;
               state <= (isLoad | isStore) ? waitMem : waitInstr;
            end
            waitMem: begin
               if (!memRbusy && !memWbusy) begin
                  state <= fetchInstr;
               end
            end
            default: state <= waitInstr;
         endcase
      end
   end

endmodule

// File: hw/quarkCore.sv
/* Quark RV32I core top level, single memory port for code and data.
   Word loads and stores only; no cycle counter. Reset is synchronous, active low. */
`timescale 1ns/100ps

module quarkCore (
   input  logic        clk,
   input  logic        reset,
   output logic [31:0] memAddr,
   output logic [31:0] memWdata,
   output logic [3:0]  memWmask,
   input  logic [31:0] memRdata,
   output logic        memRstrb,
   input  logic        memRbusy,
   input  logic        memWbusy
);

   logic        capture;
   logic        wbEnable;
   logic [31:0] wbData;
   logic [31:0] rs1;
   logic [31:0] rs2;
   logic [31:0] aluResult;
   logic [31:0] aluSum;
   logic        takeBranch;

   // Decoded fields shared by ALU and sequencer
   decodeIf decBus ();

   instrDecoder u_instrDecoder (
      .clk      (clk),
      .capture  (capture),
      .memRdata (memRdata),
      .dec      (decBus.producer)
   );

   registerFile u_registerFile (
      .clk      (clk),
      .capture  (capture),
      .memRdata (memRdata),
      .wbEnable (wbEnable),
      .rdId     (decBus.rdId),
      .wbData   (wbData),
      .rs1      (rs1),
      .rs2      (rs2)
   );

   aluUnit u_aluUnit (
      .dec        (decBus.consumer),
      .rs1        (rs1),
      .rs2        (rs2),
      .aluResult  (aluResult),
      .aluSum     (aluSum),
      .takeBranch (takeBranch)
   );

   execSequencer u_execSequencer (
      .clk        (clk),
      .reset      (reset),
      .dec        (decBus.consumer),
      .rs1        (rs1),
      .rs2        (rs2),
      .aluResult  (aluResult),
      .aluSum     (aluSum),
      .takeBranch (takeBranch),
      .memRdata   (memRdata),
      .memRbusy   (memRbusy),
      .memWbusy   (memWbusy),
      .capture    (capture),
      .wbEnable   (wbEnable),
      .wbData     (wbData),
      .memAddr    (memAddr),
      .memWdata   (memWdata),
      .memWmask   (memWmask),
      .memRstrb   (memRstrb)
   );

endmodule

// File: verification/clockGen.sv
/* Testbench clock and power-on reset.
   40 ns period; reset is held low for the first 8 rising edges. */
`timescale 1ns/100ps

module clockGen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Release a little after the edge, like all other stimulus
   initial begin
      reset = 1'b0;
      repeat (8) @(posedge clk);
      #5 reset = 1'b1;
   end

endmodule

// File: verification/quarkCoreTb.sv
/* Testbench for the quark core with a word memory model and random busy cycles.
   Every test runs an 8-word program from the reset address and ends in one store
   to the result word; only word accesses are modelled, 256 words in size. */
`timescale 1ns/100ps
`include "quarkCore_config.svh"

module quarkCoreTb;

   localparam int          cyclesPerTest = 64;
   localparam logic [31:0] resultAddr    = 32'h00000100;
   localparam logic [31:0] presetAddr    = 32'h00000080;
   localparam logic [31:0] progBase      = `QUARK_RESET_ADDR;
   localparam logic [6:0]  opImmC        = 7'b0010011;
   localparam logic [6:0]  opLoadC       = 7'b0000011;
   localparam logic [6:0]  opJalrC       = 7'b1100111;
   localparam logic [6:0]  opLuiC        = 7'b0110111;
   localparam logic [6:0]  opAuipcC      = 7'b0010111;

   logic        clk;
   logic        genReset;
   logic        testReset;
   logic        dutReset;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic [31:0] memRdata;
   logic        memRstrb;
   logic        memRbusy;
   logic        memWbusy;

   logic [31:0] mem [256];
   integer      seed = 5;
   int          rbusyLeft;
   int          wbusyLeft;
   int          errors;
   int          checks;
   int          cycles;
   int          cycleLimit;
   logic        storeSeen;
   logic [31:0] storeAddr;
   logic [31:0] storeData;
   logic [3:0]  storeMask;

   // Test table, one entry per test
   string       tName [$];
   logic [31:0] opA [$];
   logic [11:0] opB [$];
   logic [31:0] word4 [$];
   logic [31:0] word5 [$];
   logic [31:0] preset [$];
   logic [31:0] expData [$];

   clockGen u_clockGen (
      .clk   (clk),
      .reset (genReset)
   );

   assign dutReset = genReset & testReset;

   quarkCore u_quarkCore (
      .clk      (clk),
      .reset    (dutReset),
      .memAddr  (memAddr),
      .memWdata (memWdata),
      .memWmask (memWmask),
      .memRdata (memRdata),
      .memRstrb (memRstrb),
      .memRbusy (memRbusy),
      .memWbusy (memWbusy)
   );

   // RV32I instruction encoders
   function automatic logic [31:0] aluRegWord(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] immWord(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] storeWord(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] branchWord(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] upperWord(input logic [19:0] imm, input logic [4:0] rd,
                                              input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] jalWord(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic addTest(input string name, input logic [31:0] a, input logic [11:0] b,
                          input logic [31:0] w4, input logic [31:0] w5,
                          input logic [31:0] pre, input logic [31:0] exp);
      tName.push_back(name);
      opA.push_back(a);
      opB.push_back(b);
      word4.push_back(w4);
      word5.push_back(w5);
      preset.push_back(pre);
      expData.push_back(exp);
   endtask

   // x1 = a, x2 = b, x3 = 0x22, two test words, store x3, spin
   task automatic loadProgram(input int idx);
      logic [31:0] a;
      logic [31:0] hi;
      logic [31:0] prog [8];
      int          base;
      a       = opA[idx];
      hi      = (a + 32'h800) >> 12;
      prog[0] = upperWord(hi[19:0], 5'd1, opLuiC);
      prog[1] = immWord(a[11:0], 5'd1, 3'd0, 5'd1, opImmC);
      prog[2] = immWord(opB[idx], 5'd0, 3'd0, 5'd2, opImmC);
      prog[3] = immWord(12'h022, 5'd0, 3'd0, 5'd3, opImmC);
      prog[4] = word4[idx];
      prog[5] = word5[idx];
      prog[6] = storeWord(resultAddr[11:0], 5'd3, 5'd0);
      prog[7] = jalWord(21'd0, 5'd0);
      // Fill pattern differs for every word address
      for (int k = 0; k < 256; k++) begin
         mem[k] = 32'h5A000000 ^ (32'(k) << 2);
      end
      base = int'(progBase[9:2]);
      for (int k = 0; k < 8; k++) begin
         mem[base + k] = prog[k];
      end
      mem[presetAddr[9:2]] = preset[idx];
   endtask

   // Memory model: sample at the edge, answer 5 ns later
   always @(posedge clk) begin
      logic        rdReq;
      logic [3:0]  wrMask;
      logic [31:0] addr;
      logic [31:0] wdata;
      rdReq  = memRstrb;
      wrMask = memWmask;
      addr   = memAddr;
      wdata  = memWdata;
      // A new read only starts once the previous one has finished
      assert (!(rdReq && memRbusy)) else begin
         errors++;
         $display("Read strobe raised while the memory still signalled read busy");
      end
      #5;
      if (rdReq) begin
         memRdata  = mem[addr[9:2]];
         rbusyLeft = $random(seed) & 3;
      end else if (rbusyLeft != 0) begin
         rbusyLeft--;
      end
      if (wrMask != 4'b0000) begin
         mem[addr[9:2]] = wdata;
         storeAddr      = addr;
         storeData      = wdata;
         storeMask      = wrMask;
         storeSeen      = 1'b1;
         wbusyLeft      = $random(seed) & 3;
      end else if (wbusyLeft != 0) begin
         wbusyLeft--;
      end
      memRbusy = (rbusyLeft != 0);
      memWbusy = (wbusyLeft != 0);
   end

   // Global watchdog
   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycleLimit) begin
         $display("Timeout: no final store seen within %0d cycles", cycleLimit);
         $display("Test FAILED");
         $finish;
      end
   end

   initial begin
      memRdata   = '0;
      memRbusy   = 1'b0;
      memWbusy   = 1'b0;
      testReset  = 1'b1;
      rbusyLeft  = 0;
      wbusyLeft  = 0;
      errors     = 0;
      checks     = 0;
      cycles     = 0;
      storeSeen  = 1'b0;
      storeAddr  = '0;
      storeData  = '0;
      storeMask  = '0;
      cycleLimit = 1000000;

      // Register ALU, x1 = 0x87654321, x2 = 0x123
      addTest("add",  32'h87654321, 12'h123, aluRegWord(7'h00, 3'd0, 5'd3, 5'd1, 5'd2),
              32'h00000013, 32'h0, 32'h87654444);
      addTest("sub",  32'h87654321, 12'h123, aluRegWord(7'h20, 3'd0, 5'd3, 5'd1, 5'd2),
              32'h00000013, 32'h0, 32'h876541FE);
      addTest("and",  32'h87654321, 12'h123, aluRegWord(7'h00, 3'd7, 5'd3, 5'd1, 5'd2),
              32'h00000013, 32'h0, 32'h00000121);
      addTest("or",   32'h87654321, 12'h123, aluRegWord(7'h00, 3'd6, 5'd3, 5'd1, 5'd2),
              32'h00000013, 32'h0, 32'h87654323);
      addTest("xor",  32'h87654321, 12'h123, aluRegWord(7'h00, 3'd4, 5'd3, 5'd1, 5'd2),
              32'h00000013, 32'h0, 32'h87654202);
      addTest("slt",  32'h87654321, 12'h123, aluRegWord(7'h00, 3'd2, 5'd3, 5'd1, 5'd2),
              32'h00000013, 32'h0, 32'h00000001);
      addTest("sltu", 32'h87654321, 12'h123, aluRegWord(7'h00, 3'd3, 5'd3, 5'd1, 5'd2),
              32'h00000013, 32'h0, 32'h00000000);

      // Shifts by 4; register amount 0x24 keeps only its low 5 bits
      addTest("sll",  32'h87654321, 12'h024, aluRegWord(7'h00, 3'd1, 5'd3, 5'd1, 5'd2),
              32'h00000013, 32'h0, 32'h76543210);
      addTest("srl",  32'h87654321, 12'h024, aluRegWord(7'h00, 3'd5, 5'd3, 5'd1, 5'd2),
              32'h00000013, 32'h0, 32'h08765432);
      addTest("sra",  32'h87654321, 12'h024, aluRegWord(7'h20, 3'd5, 5'd3, 5'd1, 5'd2),
              32'h00000013, 32'h0, 32'hF8765432);
      addTest("slli", 32'h87654321, 12'h024, immWord(12'h004, 5'd1, 3'd1, 5'd3, opImmC),
              32'h00000013, 32'h0, 32'h76543210);
      addTest("srli", 32'h87654321, 12'h024, immWord(12'h004, 5'd1, 3'd5, 5'd3, opImmC),
              32'h00000013, 32'h0, 32'h08765432);
      addTest("srai", 32'h87654321, 12'h024, immWord(12'h404, 5'd1, 3'd5, 5'd3, opImmC),
              32'h00000013, 32'h0, 32'hF8765432);

      // Branches skip the 0x11 marker when taken, leaving 0x22
      addTest("beq taken", 32'd5, 12'd5, branchWord(3'd0, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h22);
      addTest("beq not",   32'd5, 12'd6, branchWord(3'd0, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h11);
      addTest("bne taken", 32'd5, 12'd6, branchWord(3'd1, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h22);
      addTest("bne not",   32'd5, 12'd5, branchWord(3'd1, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h11);
      addTest("blt taken", 32'hFFFFFFFD, 12'd2, branchWord(3'd4, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h22);
      addTest("blt not",   32'd5, 12'd2, branchWord(3'd4, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h11);
      addTest("bge taken", 32'd5, 12'd2, branchWord(3'd5, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h22);
      addTest("bge not",   32'hFFFFFFFD, 12'd2, branchWord(3'd5, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h11);
      addTest("bltu taken", 32'd2, 12'd5, branchWord(3'd6, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h22);
      addTest("bltu not",  32'hFFFFFFFD, 12'd2, branchWord(3'd6, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h11);
      addTest("bgeu taken", 32'hFFFFFFFD, 12'd2, branchWord(3'd7, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h22);
      addTest("bgeu not",  32'd2, 12'd5, branchWord(3'd7, 5'd1, 5'd2, 13'd8),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, 32'h11);

      // Jump word sits at offset 16, link is offset 20
      // Skipped word would overwrite the link with the 0x11 marker
      addTest("jal",   32'd0, 12'd0, jalWord(21'd8, 5'd3),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, progBase + 32'h14);
      addTest("jalr",  32'd0, progBase[11:0] + 12'd24, immWord(12'h0, 5'd2, 3'd0, 5'd3, opJalrC),
              immWord(12'h011, 5'd0, 3'd0, 5'd3, opImmC), 32'h0, progBase + 32'h14);
      addTest("auipc", 32'd0, 12'd0, upperWord(20'h12345, 5'd3, opAuipcC),
              32'h00000013, 32'h0, progBase + 32'h12345010);

      // Word load under busy stalls, and a load into x0
      addTest("lw sw", 32'd0, 12'd0, immWord(presetAddr[11:0], 5'd0, 3'd2, 5'd3, opLoadC),
              32'h00000013, 32'hC0DE5A17, 32'hC0DE5A17);
      addTest("x0 write", 32'd0, 12'd0, immWord(presetAddr[11:0], 5'd0, 3'd2, 5'd0, opLoadC),
              aluRegWord(7'h00, 3'd0, 5'd3, 5'd0, 5'd0), 32'hC0DE5A17, 32'h00000000);

      cycleLimit = cyclesPerTest * tName.size();

      for (int i = 0; i < tName.size(); i++) begin
         @(posedge clk);
         #5;
         testReset = 1'b0;
         storeSeen = 1'b0;
         loadProgram(i);
         repeat (8) @(posedge clk);
         #5 testReset = 1'b1;
         while (!storeSeen) begin
            @(posedge clk);
         end
         checks += 3;
         assert (storeAddr == resultAddr) else begin
            errors++;
            $display("FAILED %s address: expected %h actual %h", tName[i], resultAddr,
                     storeAddr);
         end
         assert (storeData == expData[i]) else begin
            errors++;
            $display("FAILED %s data: expected %h actual %h", tName[i], expData[i], storeData);
         end
         assert (storeMask == 4'b1111) else begin
            errors++;
            $display("FAILED %s mask: expected 1111 actual %b", tName[i], storeMask);
         end
      end

      $display("Tests: %0d, checks: %0d, errors: %0d", tName.size(), checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: quarkCore.f
+incdir+include
hw/isaPkg.sv
hw/corePkg.sv
hw/decodeIf.sv
hw/instrDecoder.sv
hw/registerFile.sv
hw/aluUnit.sv
hw/execSequencer.sv
hw/quarkCore.sv
verification/clockGen.sv
verification/quarkCoreTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the quark core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module quarkCoreTb \
   -f quarkCore.f -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VquarkCoreTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" sim.log; then
   exit 1
fi
exit 0
